// ==== source/pipe_pkg.sv ====
package pipe_pkg;

  localparam int XLEN   = 32;
  localparam int REG_AW = 5;

  // one bit per stage, bit 0 is the pc
  typedef logic [5:0] ctrl_vec_t;

  localparam int STG_PC     = 0;
  localparam int STG_IF_ID  = 1;
  localparam int STG_ID_EX  = 2;
  localparam int STG_EX_MEM = 3;
  localparam int STG_MEM_WB = 4;
  localparam int STG_WB     = 5;

  // payload of if/id, id/ex and ex/mem
  typedef struct packed {
    logic [XLEN-1:0]   pc;
    logic [REG_AW-1:0] rd;
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic              is_load;
    logic              is_mem;
  } inst_t;

  typedef struct packed {
    logic [XLEN-1:0]   pc;
    logic [REG_AW-1:0] rd;
  } wb_t;

  // stall / flush pairs per hazard
  localparam ctrl_vec_t RAM_MEM_STALL    = 6'b001111;
  localparam ctrl_vec_t RAM_MEM_FLUSH    = 6'b010000;
  localparam ctrl_vec_t RAM_IF_STALL     = 6'b000001; // pc only
  localparam ctrl_vec_t RAM_IF_FLUSH     = 6'b000010; // bubble into if/id
  localparam ctrl_vec_t TRAP_FLUSH_STALL = 6'b000010;
  localparam ctrl_vec_t TRAP_FLUSH_FLUSH = 6'b001110;
  localparam ctrl_vec_t TRAP_STALL_STALL = 6'b111111;
  localparam ctrl_vec_t TRAP_STALL_FLUSH = 6'b001110;
  localparam ctrl_vec_t JUMP_STALL       = 6'b000010;
  localparam ctrl_vec_t JUMP_FLUSH       = 6'b000110;
  localparam ctrl_vec_t MUL_DIV_STALL    = 6'b000111;
  localparam ctrl_vec_t MUL_DIV_FLUSH    = 6'b001000;
  localparam ctrl_vec_t LOAD_USE_STALL   = 6'b000011;
  localparam ctrl_vec_t LOAD_USE_FLUSH   = 6'b000100;
  localparam ctrl_vec_t RESET_STALL      = 6'b000000;
  localparam ctrl_vec_t RESET_FLUSH      = 6'b011111;

endpackage

// ==== source/hazard_req_if.sv ====
`timescale 1ns/1ps

// level requests into the pipeline controller
interface hazard_req_if;

  logic ram_if;     // fetch not yet done
  logic ram_mem;    // data access pending
  logic load_use;
  logic jump;
  logic mul_div;
  logic trap_stall;
  logic trap_flush;

  modport arb (output ram_if, output ram_mem);

  modport haz (output load_use);

  modport ctrl (
    input ram_if, ram_mem, load_use, jump,
    input mul_div, trap_stall, trap_flush
  );

endinterface

// ==== source/hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit import pipe_pkg::*; (
  input  inst_t        id_i,
  input  logic         id_valid_i,
  input  inst_t        ex_i,
  input  logic         ex_valid_i,
  hazard_req_if.haz    req
);

  logic ex_is_load;
  logic rs1_hit;
  logic rs2_hit;

  // x0 never carries a dependency
  assign ex_is_load = ex_valid_i && ex_i.is_load && (ex_i.rd != '0);

  assign rs1_hit = (id_i.rs1 == ex_i.rd);
  assign rs2_hit = (id_i.rs2 == ex_i.rd);

  // load data only arrives after mem, so the consumer waits one cycle
  assign req.load_use = ex_is_load && id_valid_i && (rs1_hit || rs2_hit);

endmodule

// ==== source/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter (
  input  logic       clk,
  input  logic       rst,
  output logic       fetch_req_o,
  output logic       data_req_o,
  output logic       mem_grant_data_o,
  input  logic       mem_ready_i,
  input  logic       mem_pending_i,   // ex/mem holds a mem op
  output logic       fetch_done_o,
  output logic       data_done_o,
  hazard_req_if.arb  req
);

  logic busy_q;
  logic grant_q;     // 1 = data side owns the port
  logic port_active;
  logic xfer_done;

  assign fetch_req_o = !rst;
  assign data_req_o  = !rst && mem_pending_i;

  // fetch always asks, so the port never idles out of reset
  assign port_active = fetch_req_o || data_req_o || busy_q;

  // data first when idle, otherwise keep the latched owner
  assign mem_grant_data_o = busy_q ? grant_q : data_req_o;

  assign xfer_done    = port_active && mem_ready_i;
  assign data_done_o  = xfer_done && mem_grant_data_o;
  assign fetch_done_o = xfer_done && !mem_grant_data_o && fetch_req_o;

  // stall only while the access is still outstanding
  assign req.ram_mem = data_req_o && !data_done_o;
  assign req.ram_if  = fetch_req_o && !fetch_done_o;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= 1'b0;
    end else begin
      busy_q <= port_active && !mem_ready_i;
    end
  end

  always_ff @(posedge clk) begin
    grant_q <= mem_grant_data_o; // owner of the access in flight
  end

  // an access in flight keeps its owner and its requester until ready
  a_grant_hold: assert property (
    @(posedge clk) disable iff (rst)
    (port_active && !mem_ready_i) |=>
      ($stable(mem_grant_data_o) && (data_req_o || !mem_grant_data_o))
  ) else $error("memory grant moved or lost its request before mem_ready_i");

endmodule

// ==== source/pipeline_control.sv ====
`timescale 1ns/1ps

module pipeline_control import pipe_pkg::*; (
  input  logic        rst,
  hazard_req_if.ctrl  req,
  output ctrl_vec_t   stall_o,
  output ctrl_vec_t   flush_o
);

  // later stages win, memory first since it owns the shared port
  always_comb begin
    if (rst) begin
      stall_o = RESET_STALL;
      flush_o = RESET_FLUSH;
    end else if (req.ram_mem) begin
      stall_o = RAM_MEM_STALL;
      flush_o = RAM_MEM_FLUSH;
    end else if (req.ram_if) begin
      stall_o = RAM_IF_STALL;   // bubble instead of holding if/id
      flush_o = RAM_IF_FLUSH;
    end else if (req.trap_flush) begin
      stall_o = TRAP_FLUSH_STALL;
      flush_o = TRAP_FLUSH_FLUSH;
    end else if (req.trap_stall) begin
      // whole pipe frozen, younger stages squashed
      stall_o = TRAP_STALL_STALL;
      flush_o = TRAP_STALL_FLUSH;
    end else if (req.jump) begin
      stall_o = JUMP_STALL;
      flush_o = JUMP_FLUSH;
    end else if (req.mul_div) begin
      stall_o = MUL_DIV_STALL;
      flush_o = MUL_DIV_FLUSH;
    end else if (req.load_use) begin
      stall_o = LOAD_USE_STALL;
      flush_o = LOAD_USE_FLUSH;
    end else begin
      stall_o = '0;
      flush_o = '0;
    end
  end

  // writeback is past the point of no return
  always_comb begin
    a_no_wb_flush: assert (flush_o[STG_WB] == 1'b0)
      else $error("flush reached the writeback stage");
  end

endmodule

// ==== source/stage_reg.sv ====
`timescale 1ns/1ps

module stage_reg #(
  parameter type T = logic
) (
  input  logic clk,
  input  logic rst,
  input  logic stall_i,
  input  logic flush_i,
  input  T     d_i,
  input  logic d_valid_i,
  output T     q_o,
  output logic q_valid_o
);

  // flush beats stall
  always_ff @(posedge clk) begin
    if (rst) begin
      q_valid_o <= 1'b0;
    end else if (flush_i) begin
      q_valid_o <= 1'b0;
    end else if (!stall_i) begin
      q_valid_o <= d_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_i && !flush_i) begin
      q_o <= d_i;
    end
  end

endmodule

// ==== source/pipe_top.sv ====
`timescale 1ns/1ps

module pipe_top import pipe_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic [REG_AW-1:0] rd_i,
  input  logic [REG_AW-1:0] rs1_i,
  input  logic [REG_AW-1:0] rs2_i,
  input  logic              load_i,
  input  logic              mem_i,
  input  logic              jump_i,
  input  logic [XLEN-1:0]   jump_target_i,
  input  logic              mul_div_busy_i,
  input  logic              trap_stall_i,
  input  logic              trap_flush_i,
  input  logic              mem_ready_i,
  output logic              fetch_req_o,
  output logic              data_req_o,
  output logic              mem_grant_data_o,
  output ctrl_vec_t         stall_o,
  output ctrl_vec_t         flush_o,
  output logic              wb_valid_o,
  output logic [XLEN-1:0]   wb_pc_o
);

  logic [XLEN-1:0] pc_q;
  logic            fetch_done;

  inst_t fetch_inst;
  inst_t if_id_q, id_ex_q, ex_mem_q;
  logic  if_id_valid, id_ex_valid, ex_mem_valid;
  wb_t   mem_wb_d, mem_wb_q;
  logic  mem_wb_valid;

  hazard_req_if hreq ();

  // requests resolved outside this block
  assign hreq.jump       = jump_i;
  assign hreq.mul_div    = mul_div_busy_i;
  assign hreq.trap_stall = trap_stall_i;
  assign hreq.trap_flush = trap_flush_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= '0;
    end else if (!stall_o[STG_PC]) begin
      pc_q <= jump_i ? jump_target_i : pc_q + XLEN'(4);
    end
  end

  assign fetch_inst = '{pc: pc_q, rd: rd_i, rs1: rs1_i, rs2: rs2_i,
                        is_load: load_i, is_mem: mem_i};

  mem_arbiter u_arb (
    .clk, .rst,
    .fetch_req_o, .data_req_o, .mem_grant_data_o, .mem_ready_i,
    .mem_pending_i (ex_mem_valid && ex_mem_q.is_mem),
    .fetch_done_o  (fetch_done),
    .data_done_o   (),
    .req           (hreq.arb)
  );

  hazard_unit u_haz (
    .id_i (if_id_q), .id_valid_i (if_id_valid),
    .ex_i (id_ex_q), .ex_valid_i (id_ex_valid),
    .req  (hreq.haz)
  );

  pipeline_control u_ctrl (.rst, .req (hreq.ctrl), .stall_o, .flush_o);

  // if/id only picks up a completed fetch
  stage_reg #(.T (inst_t)) u_if_id (
    .clk, .rst, .stall_i (stall_o[STG_IF_ID]), .flush_i (flush_o[STG_IF_ID]),
    .d_i (fetch_inst), .d_valid_i (fetch_done), .q_o (if_id_q), .q_valid_o (if_id_valid)
  );

  stage_reg #(.T (inst_t)) u_id_ex (
    .clk, .rst, .stall_i (stall_o[STG_ID_EX]), .flush_i (flush_o[STG_ID_EX]),
    .d_i (if_id_q), .d_valid_i (if_id_valid), .q_o (id_ex_q), .q_valid_o (id_ex_valid)
  );

  stage_reg #(.T (inst_t)) u_ex_mem (
    .clk, .rst, .stall_i (stall_o[STG_EX_MEM]), .flush_i (flush_o[STG_EX_MEM]),
    .d_i (id_ex_q), .d_valid_i (id_ex_valid), .q_o (ex_mem_q), .q_valid_o (ex_mem_valid)
  );

  assign mem_wb_d = '{pc: ex_mem_q.pc, rd: ex_mem_q.rd};

  stage_reg #(.T (wb_t)) u_mem_wb (
    .clk, .rst, .stall_i (stall_o[STG_MEM_WB]), .flush_i (flush_o[STG_MEM_WB]),
    .d_i (mem_wb_d), .d_valid_i (ex_mem_valid), .q_o (mem_wb_q), .q_valid_o (mem_wb_valid)
  );

  // retire unless a trap freezes writeback
  assign wb_valid_o = !rst && mem_wb_valid && !stall_o[STG_WB];
  assign wb_pc_o    = mem_wb_q.pc;

  // a load-use bubble holds the consumer in if/id and empties id/ex
  a_load_use_bubble: assert property (
    @(posedge clk) disable iff (rst)
    (stall_o == LOAD_USE_STALL && flush_o == LOAD_USE_FLUSH)
      |=> (!id_ex_valid && $stable(if_id_q))
  ) else $error("load-use bubble not inserted");

endmodule

// ==== tb/pipe_model.svh ====
`ifndef PIPE_MODEL_SVH
`define PIPE_MODEL_SVH

// registered state of the reference model
logic                        m_busy;
logic                        m_grant_q;
logic [XLEN-1:0]             m_pc;
inst_t                       m_if_id;
inst_t                       m_id_ex;
inst_t                       m_ex_mem;
wb_t                         m_mem_wb;
logic [STG_MEM_WB:STG_IF_ID] m_valid;

// per-cycle view, recomputed once the inputs settle
logic      m_fetch_req, m_data_req, m_grant, m_port_active;
logic      m_fetch_done, m_data_done;
logic      m_ram_if, m_ram_mem, m_load_use;
ctrl_vec_t m_stall, m_flush;
logic      m_wb_valid;

task automatic clear_model_state();
  m_busy    = 1'b0;
  m_grant_q = 1'b0;
  m_pc      = '0;
  m_valid   = '0;
endtask

// flush empties the stage, stall keeps it
function automatic logic next_valid(logic flush, logic stall, logic cur, logic d);
  if (flush) begin
    return 1'b0;
  end
  return stall ? cur : d;
endfunction

task automatic evaluate_requests();
  logic dep;
  m_fetch_req   = !rst;
  m_data_req    = !rst && m_valid[STG_EX_MEM] && m_ex_mem.is_mem;
  m_port_active = m_fetch_req || m_data_req || m_busy;
  m_grant       = m_busy ? m_grant_q : m_data_req; // idle port goes to data
  m_data_done   = m_port_active && mem_ready_i && m_grant;
  m_fetch_done  = m_port_active && mem_ready_i && !m_grant && m_fetch_req;
  m_ram_mem     = m_data_req && !m_data_done;
  m_ram_if      = m_fetch_req && !m_fetch_done;

  dep = (m_if_id.rs1 == m_id_ex.rd) || (m_if_id.rs2 == m_id_ex.rd);
  m_load_use = m_valid[STG_ID_EX] && m_id_ex.is_load && (m_id_ex.rd != '0)
               && m_valid[STG_IF_ID] && dep;

  if (rst) {m_stall, m_flush} = {RESET_STALL, RESET_FLUSH};
  else if (m_ram_mem) {m_stall, m_flush} = {RAM_MEM_STALL, RAM_MEM_FLUSH};
  else if (m_ram_if) {m_stall, m_flush} = {RAM_IF_STALL, RAM_IF_FLUSH};
  else if (trap_flush_i) {m_stall, m_flush} = {TRAP_FLUSH_STALL, TRAP_FLUSH_FLUSH};
  else if (trap_stall_i) {m_stall, m_flush} = {TRAP_STALL_STALL, TRAP_STALL_FLUSH};
  else if (jump_i) {m_stall, m_flush} = {JUMP_STALL, JUMP_FLUSH};
  else if (mul_div_busy_i) {m_stall, m_flush} = {MUL_DIV_STALL, MUL_DIV_FLUSH};
  else if (m_load_use) {m_stall, m_flush} = {LOAD_USE_STALL, LOAD_USE_FLUSH};
  else {m_stall, m_flush} = '0;

  m_wb_valid = !rst && m_valid[STG_MEM_WB] && !m_stall[STG_WB];
endtask

task automatic advance_model();
  inst_t fetched;
  fetched = '{pc: m_pc, rd: rd_i, rs1: rs1_i, rs2: rs2_i, is_load: load_i, is_mem: mem_i};
  if (rst) begin
    clear_model_state();
  end else begin
    // oldest stage first, each one reads its predecessor's old value
    m_valid[STG_MEM_WB] = next_valid(m_flush[STG_MEM_WB], m_stall[STG_MEM_WB],
                                     m_valid[STG_MEM_WB], m_valid[STG_EX_MEM]);
    if (!m_stall[STG_MEM_WB]) m_mem_wb = '{pc: m_ex_mem.pc, rd: m_ex_mem.rd};
    m_valid[STG_EX_MEM] = next_valid(m_flush[STG_EX_MEM], m_stall[STG_EX_MEM],
                                     m_valid[STG_EX_MEM], m_valid[STG_ID_EX]);
    if (!m_stall[STG_EX_MEM]) m_ex_mem = m_id_ex;
    m_valid[STG_ID_EX] = next_valid(m_flush[STG_ID_EX], m_stall[STG_ID_EX],
                                    m_valid[STG_ID_EX], m_valid[STG_IF_ID]);
    if (!m_stall[STG_ID_EX]) m_id_ex = m_if_id;
    m_valid[STG_IF_ID] = next_valid(m_flush[STG_IF_ID], m_stall[STG_IF_ID],
                                    m_valid[STG_IF_ID], m_fetch_done);
    if (!m_stall[STG_IF_ID]) m_if_id = fetched;
    if (!m_stall[STG_PC]) m_pc = jump_i ? jump_target_i : m_pc + 32'd4;
    m_busy    = m_port_active && !mem_ready_i; // access still in flight
    m_grant_q = m_grant;
  end
endtask

`endif

// ==== tb/tb_pipe_top.sv ====
`timescale 1ns/1ps

module tb_pipe_top import pipe_pkg::*; ();

  localparam int NUM_CYCLES     = 2000;
  localparam int RST_CYCLES     = 3;
  localparam int TIMEOUT_CYCLES = NUM_CYCLES + NUM_CYCLES / 10;

  logic              clk;
  logic              rst;
  logic [REG_AW-1:0] rd_i, rs1_i, rs2_i;
  logic              load_i, mem_i, jump_i;
  logic [XLEN-1:0]   jump_target_i;
  logic              mul_div_busy_i, trap_stall_i, trap_flush_i, mem_ready_i;
  logic              fetch_req_o, data_req_o, mem_grant_data_o;
  ctrl_vec_t         stall_o, flush_o;
  logic              wb_valid_o;
  logic [XLEN-1:0]   wb_pc_o;

  integer seed = 32'h5644deb8;
  int     cycle_count = 0;
  int     retired = 0;
  int     load_use_seen = 0;
  logic   hold_grant;  // previous access still outstanding
  logic   prev_grant;

  `include "pipe_model.svh"

  pipe_top dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      abort_run($sformatf("timeout, run still going after %0d cycles", cycle_count));
    end
  end

  task automatic abort_run(string what);
    $display("%s", what);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic check_vec(string name, ctrl_vec_t got, ctrl_vec_t exp);
    if (got !== exp) abort_run($sformatf("Fail %s: got %h, expected %h", name, got, exp));
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) abort_run($sformatf("Fail %s: got %h, expected %h", name, got, exp));
  endtask

  task automatic check_pc(string name, logic [XLEN-1:0] got, logic [XLEN-1:0] exp);
    if (got !== exp) abort_run($sformatf("Fail %s: got %h, expected %h", name, got, exp));
  endtask

  function automatic logic chance(int pct);
    logic [31:0] r;
    r = $random(seed);
    return (r % 100) < pct;
  endfunction

  task automatic drive_inputs();
    logic [31:0] r;
    r = $random(seed);
    rd_i           = REG_AW'(r[1:0]); // x0..x3, so dependencies are common
    rs1_i          = REG_AW'(r[3:2]);
    rs2_i          = REG_AW'(r[5:4]);
    load_i         = chance(30);
    mem_i          = load_i || chance(15);
    jump_i         = chance(10);
    jump_target_i  = $random(seed) & ~32'h3;
    mul_div_busy_i = chance(10);
    trap_stall_i   = chance(3);
    trap_flush_i   = chance(3);
    mem_ready_i    = chance(50);
  endtask

  task automatic compare_outputs(int cyc);
    check_vec("stall_o", stall_o, m_stall);
    check_vec("flush_o", flush_o, m_flush);
    check_bit("fetch_req_o", fetch_req_o, m_fetch_req);
    check_bit("data_req_o", data_req_o, m_data_req);
    check_bit("wb_valid_o", wb_valid_o, m_wb_valid);
    if (rst) begin
      check_vec("stall_o", stall_o, RESET_STALL);
      check_vec("flush_o", flush_o, RESET_FLUSH);
      check_bit("fetch_req_o", fetch_req_o, 1'b0);
      check_bit("data_req_o", data_req_o, 1'b0);
      check_bit("wb_valid_o", wb_valid_o, 1'b0);
    end else begin
      check_bit("mem_grant_data_o", mem_grant_data_o, m_grant);
      if (hold_grant) check_bit("mem_grant_data_o", mem_grant_data_o, prev_grant);
    end
    if (cyc == RST_CYCLES) begin
      // pipeline is still empty
      check_bit("data_req_o", data_req_o, 1'b0);
      check_bit("wb_valid_o", wb_valid_o, 1'b0);
    end
    if (m_wb_valid) begin
      check_pc("wb_pc_o", wb_pc_o, m_mem_wb.pc);
      retired++;
    end
    if (!rst && m_load_use && !m_ram_mem && !m_ram_if && !trap_flush_i && !trap_stall_i
        && !jump_i && !mul_div_busy_i) begin
      check_vec("stall_o", stall_o, LOAD_USE_STALL);
      check_vec("flush_o", flush_o, LOAD_USE_FLUSH);
      load_use_seen++;
    end
    hold_grant = !rst && m_port_active && !mem_ready_i;
    prev_grant = m_grant;
  endtask

  initial begin
    rst = 1'b1;
    {rd_i, rs1_i, rs2_i, load_i, mem_i, jump_i} = '0;
    jump_target_i = '0;
    {mul_div_busy_i, trap_stall_i, trap_flush_i, mem_ready_i} = '0;
    hold_grant = 1'b0;
    prev_grant = 1'b0;
    clear_model_state();
    for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
      rst = (cyc < RST_CYCLES);
      drive_inputs();
      #1;
      evaluate_requests();
      compare_outputs(cyc);
      @(posedge clk);
      advance_model();
      @(negedge clk);
    end
    if (retired > 0 && load_use_seen > 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("too little activity: %0d retirements, %0d load-use stalls",
               retired, load_use_seen);
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+tb
source/pipe_pkg.sv
source/hazard_req_if.sv
source/hazard_unit.sv
source/mem_arbiter.sv
source/pipeline_control.sv
source/stage_reg.sv
source/pipe_top.sv
tb/tb_pipe_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile the pipeline control testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f build.f --top-module tb_pipe_top -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -q "ALL CHECKS PASSED" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
